// ==== common/rcc_pkg.sv ====
package rcc_pkg;

  // ========================================================================
  // domain indexing
  // ========================================================================
  localparam int NUM_DOM = 3;
  localparam int DOM_SYS = 0;
  localparam int DOM_D1  = 1;
  localparam int DOM_D2  = 2;

  // cpu1 and cpu2
  localparam int NUM_CPU = 2;
  // d1, d2, d3 stop requests
  localparam int NUM_LP_DOM = 3;

  // ========================================================================
  // timing, in sys_clk cycles
  // ========================================================================
  // reset hold after the domain hold drops
  localparam int DOM_RST_CYCLES [0:NUM_DOM-1] = '{4, 10, 10};
  // clock-on delay after domain reset release
  localparam int DOM_CLK_DELAY  [0:NUM_DOM-1] = '{8, 8, 8};
  localparam int CPU_CLK_DELAY = 8;

  // largest entry, floor given by the caller
  function automatic int dom_max(input int vals [0:NUM_DOM-1], input int floor_val);
    int m;
    m = floor_val;
    for (int i = 0; i < NUM_DOM; i++) begin
      if (vals[i] > m) m = vals[i];
    end
    return m;
  endfunction

  localparam int RST_CNT_W = $clog2(dom_max(DOM_RST_CYCLES, 1) + 1);
  localparam int CLK_CNT_W = $clog2(dom_max(DOM_CLK_DELAY, CPU_CLK_DELAY) + 1);

  // one bit per sequenced domain
  typedef logic [NUM_DOM-1:0] dom_vec_t;

endpackage

// ==== rcc_rst_ctrl.f ====
common/rcc_pkg.sv
rtl/rcc_rst_sources.sv
rst_seq/rcc_domain_rst_seq.sv
rtl/rcc_rst_dist.sv
rtl/rcc_lp_req.sv
rtl/rcc_rst_ctrl.sv
verif/tb_rcc_rst_ctrl.sv

// ==== rst_seq/rcc_domain_rst_seq.sv ====
`timescale 1ns/1ns

module rcc_domain_rst_seq
  import rcc_pkg::*;
#(
  parameter int RST_CYCLES = 10,
  parameter int CLK_DELAY  = 8
) (
  input  logic sys_clk,
  input  logic reset,
  input  logic hold,
  input  logic release_ok,
  input  logic arcg_on,
  output logic rst_n,
  output logic clk_en
);

  logic [RST_CNT_W-1:0] rst_cnt;
  logic                 rst_done;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic                 clk_ready;

  // ========================================================================
  // reset duration
  // ========================================================================
  // saturates at the duration, cleared by hold
  assign rst_done = (rst_cnt == RST_CNT_W'(RST_CYCLES));

  always_ff @(posedge sys_clk) begin
    if (reset || hold) begin
      rst_cnt <= '0;
    end else if (!rst_done) begin
      rst_cnt <= rst_cnt + RST_CNT_W'(1);
    end
  end

  // release once duration done and release_ok seen
  // stays released until the next hold
  always_ff @(posedge sys_clk) begin
    if (reset || hold) begin
      rst_n <= 1'b0;
    end else if (rst_done && release_ok) begin
      rst_n <= 1'b1;
    end
  end

  // ========================================================================
  // clock enable after release
  // ========================================================================
  // counts the cycles spent out of reset
  // enable is registered, so stop one short of the delay
  assign clk_ready = (clk_cnt == CLK_CNT_W'(CLK_DELAY - 1));

  always_ff @(posedge sys_clk) begin
    if (reset || hold || !rst_n) begin
      clk_cnt <= '0;
    end else if (!clk_ready) begin
      clk_cnt <= clk_cnt + CLK_CNT_W'(1);
    end
  end

  // arcg off: clock runs free, even in reset
  // hold drops clk_en on the same edge as rst_n
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      clk_en <= 1'b0;
    end else if (!arcg_on) begin
      clk_en <= 1'b1;
    end else begin
      clk_en <= rst_n && !hold && clk_ready;
    end
  end

endmodule

// ==== rtl/rcc_lp_req.sv ====
`timescale 1ns/1ns

module rcc_lp_req
  import rcc_pkg::*;
(
  input  logic sys_clk,
  input  logic reset,
  input  logic sys_rst_n,
  // cpu sleep state and peripheral allocation
  input  logic c1_deepsleep,
  input  logic c2_deepsleep,
  input  logic d3_deepsleep,
  input  logic c2_per_alloc_d1,
  input  logic c1_per_alloc_d2,
  // bridge busy flags
  input  logic axi_d1_busy,
  input  logic ahb3_d1_busy,
  input  logic apb3_d1_busy,
  input  logic flash_busy,
  input  logic ahb1_d2_busy,
  input  logic ahb2_d2_busy,
  input  logic apb1_d2_busy,
  input  logic apb2_d2_busy,
  input  logic ahb4_d3_busy,
  input  logic apb4_d3_busy,
  // wakeups from pwr
  input  logic pwr_d1_wkup,
  input  logic pwr_d2_wkup,
  input  logic pwr_d3_wkup,
  output logic pwr_d1_req,
  output logic pwr_d2_req,
  output logic pwr_d3_req
);

  logic                  d1_busy;
  logic                  d2_busy;
  logic                  d3_busy;
  // bit order is d1, d2, d3
  logic [NUM_LP_DOM-1:0] req_set;
  logic [NUM_LP_DOM-1:0] req_wkup;
  logic [NUM_LP_DOM-1:0] req_q;

  // ========================================================================
  // busy aggregation
  // ========================================================================
  assign d1_busy = axi_d1_busy || ahb3_d1_busy || apb3_d1_busy || flash_busy;
  assign d2_busy = ahb1_d2_busy || ahb2_d2_busy || apb1_d2_busy || apb2_d2_busy;
  // d3 cannot stop while anything below it is busy
  assign d3_busy = d1_busy || d2_busy || ahb4_d3_busy || apb4_d3_busy;

  // c1 stopped, and c2 stopped or owns nothing in d1
  assign req_set[0] = c1_deepsleep && (c2_deepsleep || !c2_per_alloc_d1) && !d1_busy;
  // mirror for d2
  assign req_set[1] = c2_deepsleep && (c1_deepsleep || !c1_per_alloc_d2) && !d2_busy;
  // everyone asleep
  assign req_set[2] = c1_deepsleep && c2_deepsleep && d3_deepsleep && !d3_busy;

  assign req_wkup = {pwr_d3_wkup, pwr_d2_wkup, pwr_d1_wkup};

  // ========================================================================
  // request latches
  // ========================================================================
  // set-dominant, wakeup clears, forced low in system reset
  always_ff @(posedge sys_clk) begin
    if (reset || !sys_rst_n) begin
      req_q <= '0;
    end else begin
      req_q <= req_set | (req_q & ~req_wkup);
    end
  end

  assign pwr_d1_req = req_q[0];
  assign pwr_d2_req = req_q[1];
  assign pwr_d3_req = req_q[2];

endmodule

// ==== rtl/rcc_rst_ctrl.sv ====
`timescale 1ns/1ns

module rcc_rst_ctrl
  import rcc_pkg::*;
(
  input  logic sys_clk,
  input  logic reset,
  input  logic arcg_on,
  // reset sources
  input  logic nrst_in,
  input  logic pwr_vcore_ok,
  input  logic obl_done,
  input  logic flash_obl_reload,
  input  logic flash_power_ok,
  input  logic hsi_rdy,
  input  logic pwr_d1_ok,
  input  logic pwr_d2_ok,
  input  logic pwr_bor_rst,
  input  logic lpwr1_rst,
  input  logic lpwr2_rst,
  input  logic iwdg1_rst,
  input  logic iwdg2_rst,
  input  logic wwdg1_rst,
  input  logic wwdg2_rst,
  input  logic ww1rsc,
  input  logic ww2rsc,
  input  logic cpu1_sftrst,
  input  logic cpu2_sftrst,
  // low-power inputs
  input  logic c1_deepsleep,
  input  logic c2_deepsleep,
  input  logic d3_deepsleep,
  input  logic c2_per_alloc_d1,
  input  logic c1_per_alloc_d2,
  input  logic axi_d1_busy,
  input  logic ahb3_d1_busy,
  input  logic apb3_d1_busy,
  input  logic flash_busy,
  input  logic ahb1_d2_busy,
  input  logic ahb2_d2_busy,
  input  logic apb1_d2_busy,
  input  logic apb2_d2_busy,
  input  logic ahb4_d3_busy,
  input  logic apb4_d3_busy,
  input  logic pwr_d1_wkup,
  input  logic pwr_d2_wkup,
  input  logic pwr_d3_wkup,
  // resets and clock enables
  output logic rst_pin_drive,
  output logic sys_rst_n,
  output logic d1_rst_n,
  output logic d2_rst_n,
  output logic sys_clk_en,
  output logic d1_clk_en,
  output logic d2_clk_en,
  output logic cpu1_rst_n,
  output logic cpu2_rst_n,
  output logic d1_bus_rst_n,
  output logic d2_bus_rst_n,
  output logic d3_bus_rst_n,
  output logic cpu1_clk_en,
  output logic cpu2_clk_en,
  // stop requests
  output logic pwr_d1_req,
  output logic pwr_d2_req,
  output logic pwr_d3_req
);

  dom_vec_t dom_hold;
  dom_vec_t dom_release_ok;
  dom_vec_t dom_rst_n;
  dom_vec_t dom_clk_en;

  rcc_rst_sources u_sources (
    .sys_clk(sys_clk), .reset(reset), .nrst_in(nrst_in),
    .pwr_vcore_ok(pwr_vcore_ok), .pwr_d1_ok(pwr_d1_ok), .pwr_d2_ok(pwr_d2_ok),
    .pwr_bor_rst(pwr_bor_rst), .obl_done(obl_done), .flash_obl_reload(flash_obl_reload),
    .flash_power_ok(flash_power_ok), .hsi_rdy(hsi_rdy),
    .lpwr1_rst(lpwr1_rst), .lpwr2_rst(lpwr2_rst),
    .iwdg1_rst(iwdg1_rst), .iwdg2_rst(iwdg2_rst),
    .wwdg1_rst(wwdg1_rst), .wwdg2_rst(wwdg2_rst), .ww1rsc(ww1rsc), .ww2rsc(ww2rsc),
    .cpu1_sftrst(cpu1_sftrst), .cpu2_sftrst(cpu2_sftrst),
    .dom_hold(dom_hold), .dom_release_ok(dom_release_ok), .rst_pin_drive(rst_pin_drive)
  );

  // ========================================================================
  // one sequencer per domain, lengths from the package tables
  // ========================================================================
  for (genvar d = 0; d < NUM_DOM; d++) begin : g_dom
    rcc_domain_rst_seq #(
      .RST_CYCLES(DOM_RST_CYCLES[d]),
      .CLK_DELAY (DOM_CLK_DELAY[d])
    ) u_seq (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .hold      (dom_hold[d]),
      .release_ok(dom_release_ok[d]),
      .arcg_on   (arcg_on),
      .rst_n     (dom_rst_n[d]),
      .clk_en    (dom_clk_en[d])
    );
  end

  assign sys_rst_n  = dom_rst_n[DOM_SYS];
  assign d1_rst_n   = dom_rst_n[DOM_D1];
  assign d2_rst_n   = dom_rst_n[DOM_D2];
  assign sys_clk_en = dom_clk_en[DOM_SYS];
  assign d1_clk_en  = dom_clk_en[DOM_D1];
  assign d2_clk_en  = dom_clk_en[DOM_D2];

  rcc_rst_dist u_dist (
    .sys_clk(sys_clk), .reset(reset), .dom_rst_n(dom_rst_n),
    .wwdg1_rst(wwdg1_rst), .wwdg2_rst(wwdg2_rst), .arcg_on(arcg_on),
    .cpu1_rst_n(cpu1_rst_n), .cpu2_rst_n(cpu2_rst_n),
    .d1_bus_rst_n(d1_bus_rst_n), .d2_bus_rst_n(d2_bus_rst_n), .d3_bus_rst_n(d3_bus_rst_n),
    .cpu1_clk_en(cpu1_clk_en), .cpu2_clk_en(cpu2_clk_en)
  );

  // stop requests cleared by system reset
  rcc_lp_req u_lp_req (
    .sys_clk(sys_clk), .reset(reset), .sys_rst_n(dom_rst_n[DOM_SYS]),
    .c1_deepsleep(c1_deepsleep), .c2_deepsleep(c2_deepsleep), .d3_deepsleep(d3_deepsleep),
    .c2_per_alloc_d1(c2_per_alloc_d1), .c1_per_alloc_d2(c1_per_alloc_d2),
    .axi_d1_busy(axi_d1_busy), .ahb3_d1_busy(ahb3_d1_busy), .apb3_d1_busy(apb3_d1_busy),
    .flash_busy(flash_busy), .ahb1_d2_busy(ahb1_d2_busy), .ahb2_d2_busy(ahb2_d2_busy),
    .apb1_d2_busy(apb1_d2_busy), .apb2_d2_busy(apb2_d2_busy),
    .ahb4_d3_busy(ahb4_d3_busy), .apb4_d3_busy(apb4_d3_busy),
    .pwr_d1_wkup(pwr_d1_wkup), .pwr_d2_wkup(pwr_d2_wkup), .pwr_d3_wkup(pwr_d3_wkup),
    .pwr_d1_req(pwr_d1_req), .pwr_d2_req(pwr_d2_req), .pwr_d3_req(pwr_d3_req)
  );

endmodule

// ==== rtl/rcc_rst_dist.sv ====
`timescale 1ns/1ns

module rcc_rst_dist
  import rcc_pkg::*;
(
  input  logic     sys_clk,
  input  logic     reset,
  input  dom_vec_t dom_rst_n,
  input  logic     wwdg1_rst,
  input  logic     wwdg2_rst,
  input  logic     arcg_on,
  output logic     cpu1_rst_n,
  output logic     cpu2_rst_n,
  output logic     d1_bus_rst_n,
  output logic     d2_bus_rst_n,
  output logic     d3_bus_rst_n,
  output logic     cpu1_clk_en,
  output logic     cpu2_clk_en
);

  logic [NUM_CPU-1:0] cpu_rst_n;
  logic [NUM_CPU-1:0] cpu_clk_en;
  logic               arcg_bypass;

  // ========================================================================
  // cpu and bus resets
  // ========================================================================
  // cpu1 sits in d1, cpu2 in d2
  // window watchdog resets only its own core
  assign cpu_rst_n[0] = dom_rst_n[DOM_SYS] && dom_rst_n[DOM_D1] && !wwdg1_rst;
  assign cpu_rst_n[1] = dom_rst_n[DOM_SYS] && dom_rst_n[DOM_D2] && !wwdg2_rst;

  assign cpu1_rst_n = cpu_rst_n[0];
  assign cpu2_rst_n = cpu_rst_n[1];

  // bus matrices follow the domains only
  assign d1_bus_rst_n = dom_rst_n[DOM_SYS] && dom_rst_n[DOM_D1];
  assign d2_bus_rst_n = dom_rst_n[DOM_SYS] && dom_rst_n[DOM_D2];
  assign d3_bus_rst_n = dom_rst_n[DOM_SYS];

  // ========================================================================
  // cpu clock enables
  // ========================================================================
  // arcg off means every cpu clock runs free
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      arcg_bypass <= 1'b0;
    end else begin
      arcg_bypass <= !arcg_on;
    end
  end

  for (genvar c = 0; c < NUM_CPU; c++) begin : g_cpu
    logic [CLK_CNT_W-1:0] dly_cnt;
    logic                 dly_done;
    logic                 clk_ready;

    // cycles since this core left reset
    assign dly_done = (dly_cnt == CLK_CNT_W'(CPU_CLK_DELAY - 1));

    always_ff @(posedge sys_clk) begin
      if (reset || !cpu_rst_n[c]) begin
        dly_cnt   <= '0;
        clk_ready <= 1'b0;
      end else begin
        if (!dly_done) dly_cnt <= dly_cnt + CLK_CNT_W'(1);
        if (dly_done) clk_ready <= 1'b1;
      end
    end

    // cpu reset is combinational, gate with it so the clock stops at once
    assign cpu_clk_en[c] = arcg_bypass || (clk_ready && cpu_rst_n[c]);
  end

  assign cpu1_clk_en = cpu_clk_en[0];
  assign cpu2_clk_en = cpu_clk_en[1];

endmodule

// ==== rtl/rcc_rst_sources.sv ====
`timescale 1ns/1ns

module rcc_rst_sources
  import rcc_pkg::*;
(
  input  logic     sys_clk,
  input  logic     reset,
  // pad and power
  input  logic     nrst_in,
  input  logic     pwr_vcore_ok,
  input  logic     pwr_d1_ok,
  input  logic     pwr_d2_ok,
  input  logic     pwr_bor_rst,
  // flash and option bytes
  input  logic     obl_done,
  input  logic     flash_obl_reload,
  input  logic     flash_power_ok,
  input  logic     hsi_rdy,
  // low-power, watchdog and software resets
  input  logic     lpwr1_rst,
  input  logic     lpwr2_rst,
  input  logic     iwdg1_rst,
  input  logic     iwdg2_rst,
  input  logic     wwdg1_rst,
  input  logic     wwdg2_rst,
  input  logic     ww1rsc,
  input  logic     ww2rsc,
  input  logic     cpu1_sftrst,
  input  logic     cpu2_sftrst,
  // per-domain hold and release
  output dom_vec_t dom_hold,
  output dom_vec_t dom_release_ok,
  output logic     rst_pin_drive
);

  logic hw_init_done;
  logic obl_rst;
  logic any_rst_src;

  // ========================================================================
  // init and option-byte state
  // ========================================================================
  // vcore up and option bytes loaded, no reload pending
  assign hw_init_done = pwr_vcore_ok && obl_done && !flash_obl_reload;
  // load still pending or reload requested
  assign obl_rst      = !obl_done || flash_obl_reload;

  // ========================================================================
  // domain hold and release conditions
  // ========================================================================
  // system held by pad or until init done
  assign dom_hold[DOM_SYS]       = !nrst_in || !hw_init_done;
  assign dom_release_ok[DOM_SYS] = hsi_rdy && flash_power_ok;

  // flash lives in d1, so d1 also waits for flash power
  assign dom_hold[DOM_D1]        = !pwr_d1_ok;
  assign dom_release_ok[DOM_D1]  = hsi_rdy && flash_power_ok;

  // d2 needs the oscillator only
  assign dom_hold[DOM_D2]        = !pwr_d2_ok;
  assign dom_release_ok[DOM_D2]  = hsi_rdy;

  // ========================================================================
  // pin reset drive
  // ========================================================================
  // window watchdogs only count when their rsc bit is set
  assign any_rst_src = obl_rst || pwr_bor_rst || lpwr1_rst || lpwr2_rst ||
                       iwdg1_rst || iwdg2_rst ||
                       (wwdg1_rst && ww1rsc) || (wwdg2_rst && ww2rsc) ||
                       cpu1_sftrst || cpu2_sftrst;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      rst_pin_drive <= 1'b0;
    end else begin
      rst_pin_drive <= any_rst_src;
    end
  end

endmodule

// ==== verif/tb_rcc_rst_ctrl.sv ====
`timescale 1ns/1ns

module tb_rcc_rst_ctrl
  import rcc_pkg::*;
();

  // ========================================================================
  // expected timing in cycles after the edge that drops every hold
  // ========================================================================
  function automatic int larger(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  localparam int SYS_UP     = DOM_RST_CYCLES[DOM_SYS] + 1;
  localparam int D1_UP      = DOM_RST_CYCLES[DOM_D1] + 1;
  localparam int D2_UP      = DOM_RST_CYCLES[DOM_D2] + 1;
  localparam int SYS_CLK_UP = SYS_UP + DOM_CLK_DELAY[DOM_SYS];
  localparam int D1_CLK_UP  = D1_UP + DOM_CLK_DELAY[DOM_D1];
  localparam int D2_CLK_UP  = D2_UP + DOM_CLK_DELAY[DOM_D2];
  // a cpu leaves reset with the later of system and its own domain
  localparam int CPU1_UP    = larger(SYS_UP, D1_UP);
  localparam int CPU2_UP    = larger(SYS_UP, D2_UP);
  localparam int SEQ_LEN    = larger(larger(SYS_CLK_UP, larger(D1_CLK_UP, D2_CLK_UP)),
                                     larger(CPU1_UP, CPU2_UP) + CPU_CLK_DELAY) + 2;
  // whole run is a few hundred cycles
  localparam int TIMEOUT_CYCLES = 3000;

  logic sys_clk, reset, arcg_on;
  logic nrst_in, pwr_vcore_ok, obl_done, flash_obl_reload, flash_power_ok, hsi_rdy;
  logic pwr_d1_ok, pwr_d2_ok, pwr_bor_rst, lpwr1_rst, lpwr2_rst, iwdg1_rst, iwdg2_rst;
  logic wwdg1_rst, wwdg2_rst, ww1rsc, ww2rsc, cpu1_sftrst, cpu2_sftrst;
  logic c1_deepsleep, c2_deepsleep, d3_deepsleep, c2_per_alloc_d1, c1_per_alloc_d2;
  logic axi_d1_busy, ahb3_d1_busy, apb3_d1_busy, flash_busy;
  logic ahb1_d2_busy, ahb2_d2_busy, apb1_d2_busy, apb2_d2_busy, ahb4_d3_busy, apb4_d3_busy;
  logic pwr_d1_wkup, pwr_d2_wkup, pwr_d3_wkup;
  logic rst_pin_drive, sys_rst_n, d1_rst_n, d2_rst_n, sys_clk_en, d1_clk_en, d2_clk_en;
  logic cpu1_rst_n, cpu2_rst_n, d1_bus_rst_n, d2_bus_rst_n, d3_bus_rst_n;
  logic cpu1_clk_en, cpu2_clk_en, pwr_d1_req, pwr_d2_req, pwr_d3_req;
  int unsigned seed;
  int cycle_cnt;

  rcc_rst_ctrl uut (.*);

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge sys_clk);
      cycle_cnt++;
    end
    $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  // ========================================================================
  // compare helpers
  // ========================================================================
  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("** Error @ %0t ns: %s = %b, expected %b", $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic check_dom(input dom_vec_t actual, input dom_vec_t expected,
                           input string what);
    if (actual !== expected) begin
      $display("** Error @ %0t ns: %s = %b, expected %b", $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  function automatic dom_vec_t dom_vec(input logic sys_up, input logic d1_up,
                                       input logic d2_up);
    dom_vec_t v;
    v[DOM_SYS] = sys_up;
    v[DOM_D1]  = d1_up;
    v[DOM_D2]  = d2_up;
    return v;
  endfunction

  function automatic dom_vec_t rst_vec();
    return dom_vec(sys_rst_n, d1_rst_n, d2_rst_n);
  endfunction

  function automatic dom_vec_t clk_vec();
    return dom_vec(sys_clk_en, d1_clk_en, d2_clk_en);
  endfunction

  // cpu and bus resets from the expected domain state
  task automatic compare_dist(input dom_vec_t dom_exp, input logic w1, input logic w2);
    check_dom(rst_vec(), dom_exp, "domain resets");
    check_bit(cpu1_rst_n, dom_exp[DOM_SYS] && dom_exp[DOM_D1] && !w1, "cpu1_rst_n");
    check_bit(cpu2_rst_n, dom_exp[DOM_SYS] && dom_exp[DOM_D2] && !w2, "cpu2_rst_n");
    check_bit(d1_bus_rst_n, dom_exp[DOM_SYS] && dom_exp[DOM_D1], "d1_bus_rst_n");
    check_bit(d2_bus_rst_n, dom_exp[DOM_SYS] && dom_exp[DOM_D2], "d2_bus_rst_n");
    check_bit(d3_bus_rst_n, dom_exp[DOM_SYS], "d3_bus_rst_n");
  endtask

  // ========================================================================
  // directed tests
  // ========================================================================
  // every domain must be in reset on entry
  task automatic power_up_sequence();
    @(posedge sys_clk);
    {arcg_on, nrst_in, pwr_vcore_ok, obl_done, flash_power_ok, hsi_rdy} <= '1;
    {pwr_d1_ok, pwr_d2_ok} <= 2'b11;
    flash_obl_reload <= 1'b0;
    @(negedge sys_clk);
    for (int n = 1; n <= SEQ_LEN; n++) begin
      @(negedge sys_clk);
      check_dom(rst_vec(), dom_vec(n >= SYS_UP, n >= D1_UP, n >= D2_UP), "domain resets");
      check_dom(clk_vec(), dom_vec(n >= SYS_CLK_UP, n >= D1_CLK_UP, n >= D2_CLK_UP),
                "domain clock enables");
      check_bit(cpu1_rst_n, n >= CPU1_UP, "cpu1_rst_n");
      check_bit(cpu2_rst_n, n >= CPU2_UP, "cpu2_rst_n");
      check_bit(cpu1_clk_en, n >= CPU1_UP + CPU_CLK_DELAY, "cpu1_clk_en");
      check_bit(cpu2_clk_en, n >= CPU2_UP + CPU_CLK_DELAY, "cpu2_clk_en");
    end
  endtask

  task automatic hold_release_gating();
    $display("hold and release gating");
    @(posedge sys_clk);
    pwr_d1_ok <= 1'b0;
    @(negedge sys_clk);
    check_bit(d1_rst_n, 1'b1, "d1_rst_n");
    @(negedge sys_clk);
    check_bit(d1_rst_n, 1'b0, "d1_rst_n");
    check_bit(cpu1_rst_n, 1'b0, "cpu1_rst_n");
    check_bit(d1_clk_en, 1'b0, "d1_clk_en");
    check_bit(cpu1_clk_en, 1'b0, "cpu1_clk_en");
    check_bit(d2_rst_n, 1'b1, "d2_rst_n");
    // supply back while flash power is still missing
    @(posedge sys_clk);
    pwr_d1_ok <= 1'b1;
    flash_power_ok <= 1'b0;
    for (int n = 0; n < 2 * D1_UP; n++) begin
      @(negedge sys_clk);
      check_bit(d1_rst_n, 1'b0, "d1_rst_n");
    end
    @(posedge sys_clk);
    flash_power_ok <= 1'b1;
    @(negedge sys_clk);
    check_bit(d1_rst_n, 1'b0, "d1_rst_n");
    @(negedge sys_clk);
    check_bit(d1_rst_n, 1'b1, "d1_rst_n");
    // clocks come back after their delays
    for (int n = 2; n <= 1 + larger(DOM_CLK_DELAY[DOM_D1], CPU_CLK_DELAY); n++) begin
      @(negedge sys_clk);
      check_bit(d1_clk_en, n >= 1 + DOM_CLK_DELAY[DOM_D1], "d1_clk_en");
      check_bit(cpu1_clk_en, n >= 1 + CPU_CLK_DELAY, "cpu1_clk_en");
    end
  endtask

  task automatic arcg_bypass();
    $display("clock gating bypass");
    @(posedge sys_clk);
    arcg_on <= 1'b0;
    {nrst_in, pwr_d1_ok, pwr_d2_ok} <= 3'b000;
    @(negedge sys_clk);
    for (int n = 1; n <= 4; n++) begin
      @(negedge sys_clk);
      check_dom(rst_vec(), '0, "domain resets");
      check_dom(clk_vec(), '1, "domain clock enables");
      check_bit(cpu1_rst_n, 1'b0, "cpu1_rst_n");
      check_bit(cpu1_clk_en, 1'b1, "cpu1_clk_en");
      check_bit(cpu2_clk_en, 1'b1, "cpu2_clk_en");
    end
    power_up_sequence();
  endtask

  task automatic watchdog_bus_resets();
    $display("watchdog and bus resets");
    @(posedge sys_clk);
    wwdg1_rst <= 1'b1;
    @(negedge sys_clk);
    compare_dist('1, 1'b1, 1'b0);
    check_bit(cpu1_clk_en, 1'b0, "cpu1_clk_en");
    @(posedge sys_clk);
    wwdg1_rst <= 1'b0;
    wwdg2_rst <= 1'b1;
    @(negedge sys_clk);
    compare_dist('1, 1'b0, 1'b1);
    check_bit(cpu2_clk_en, 1'b0, "cpu2_clk_en");
    @(posedge sys_clk);
    wwdg2_rst <= 1'b0;
    // cpu1 was released one edge earlier
    for (int n = 0; n <= CPU_CLK_DELAY; n++) begin
      @(negedge sys_clk);
      check_bit(cpu2_clk_en, n >= CPU_CLK_DELAY, "cpu2_clk_en");
      check_bit(cpu1_clk_en, n + 1 >= CPU_CLK_DELAY, "cpu1_clk_en");
    end
    // take the domains down one at a time
    @(posedge sys_clk);
    pwr_d2_ok <= 1'b0;
    repeat (2) @(negedge sys_clk);
    compare_dist(dom_vec(1'b1, 1'b1, 1'b0), 1'b0, 1'b0);
    @(posedge sys_clk);
    nrst_in <= 1'b0;
    repeat (2) @(negedge sys_clk);
    compare_dist(dom_vec(1'b0, 1'b1, 1'b0), 1'b0, 1'b0);
    @(posedge sys_clk);
    pwr_d1_ok <= 1'b0;
    repeat (2) @(negedge sys_clk);
    compare_dist('0, 1'b0, 1'b0);
    power_up_sequence();
  endtask

  task automatic pin_drive_random();
    // src bits from lsb up are obl pending, reload, bor, lpwr1, lpwr2,
    // iwdg1, iwdg2, wwdg1, wwdg2, sftrst1, sftrst2
    logic [10:0] src;
    logic [31:0] rnd;
    logic [1:0]  rsc;
    logic        expected;
    $display("pin reset drive");
    for (int i = 0; i < 40; i++) begin
      src = $urandom & $urandom & $urandom;
      rnd = $urandom;
      rsc = rnd[1:0];
      // every fourth pattern only the window watchdogs
      if (i % 4 == 0) src = {2'b00, rnd[3:2], 7'b0};
      expected = |(src & ~11'h180) || (src[7] && rsc[0]) || (src[8] && rsc[1]);
      @(posedge sys_clk);
      obl_done <= !src[0];
      {flash_obl_reload, pwr_bor_rst, lpwr1_rst, lpwr2_rst} <= {src[1], src[2], src[3], src[4]};
      {wwdg2_rst, wwdg1_rst, iwdg2_rst, iwdg1_rst} <= src[8:5];
      {cpu1_sftrst, cpu2_sftrst} <= {src[9], src[10]};
      {ww1rsc, ww2rsc} <= {rsc[0], rsc[1]};
      repeat (2) @(negedge sys_clk);
      check_bit(rst_pin_drive, expected, "rst_pin_drive");
    end
    // quiet sources and all domains down before a clean power-up
    @(posedge sys_clk);
    obl_done <= 1'b1;
    {flash_obl_reload, pwr_bor_rst, lpwr1_rst, lpwr2_rst, iwdg1_rst, iwdg2_rst} <= '0;
    {wwdg1_rst, wwdg2_rst, ww1rsc, ww2rsc, cpu1_sftrst, cpu2_sftrst} <= '0;
    {nrst_in, pwr_d1_ok, pwr_d2_ok} <= 3'b000;
    repeat (2) @(negedge sys_clk);
    check_bit(rst_pin_drive, 1'b0, "rst_pin_drive");
    check_dom(rst_vec(), '0, "domain resets");
    power_up_sequence();
  endtask

  // busy bits msb first are apb4_d3 ahb4_d3 apb2_d2 apb1_d2 ahb2_d2
  // ahb1_d2 flash apb3 ahb3 axi
  // exp and wkup bits run d3 d2 d1
  task automatic stop_req_step(input logic c1, input logic c2, input logic d3,
                               input logic [1:0] alloc, input logic [9:0] busy,
                               input logic [2:0] wkup, input logic [2:0] exp);
    @(posedge sys_clk);
    {c1_deepsleep, c2_deepsleep, d3_deepsleep} <= {c1, c2, d3};
    {c1_per_alloc_d2, c2_per_alloc_d1} <= alloc;
    {apb4_d3_busy, ahb4_d3_busy, apb2_d2_busy, apb1_d2_busy, ahb2_d2_busy} <= busy[9:5];
    {ahb1_d2_busy, flash_busy, apb3_d1_busy, ahb3_d1_busy, axi_d1_busy} <= busy[4:0];
    {pwr_d3_wkup, pwr_d2_wkup, pwr_d1_wkup} <= wkup;
    // one-cycle wakeup pulse
    @(posedge sys_clk);
    {pwr_d3_wkup, pwr_d2_wkup, pwr_d1_wkup} <= 3'b000;
    @(negedge sys_clk);
    check_bit(pwr_d1_req, exp[0], "pwr_d1_req");
    check_bit(pwr_d2_req, exp[1], "pwr_d2_req");
    check_bit(pwr_d3_req, exp[2], "pwr_d3_req");
  endtask

  task automatic low_power_requests();
    $display("low-power requests");
    stop_req_step(1, 0, 0, 2'b00, 10'h000, 3'b000, 3'b001);
    stop_req_step(0, 0, 0, 2'b00, 10'h000, 3'b000, 3'b001);
    stop_req_step(0, 0, 0, 2'b00, 10'h000, 3'b001, 3'b000);
    // peripherals of the other core keep the domain awake
    stop_req_step(1, 0, 0, 2'b01, 10'h000, 3'b000, 3'b000);
    stop_req_step(0, 1, 0, 2'b10, 10'h000, 3'b000, 3'b000);
    stop_req_step(0, 1, 0, 2'b00, 10'h000, 3'b000, 3'b010);
    // d1 busy blocks both d1 and d3
    stop_req_step(1, 1, 1, 2'b00, 10'h008, 3'b000, 3'b010);
    stop_req_step(0, 0, 0, 2'b00, 10'h000, 3'b111, 3'b000);
    stop_req_step(1, 1, 1, 2'b00, 10'h010, 3'b000, 3'b001);
    stop_req_step(1, 1, 1, 2'b00, 10'h200, 3'b000, 3'b011);
    stop_req_step(1, 1, 1, 2'b00, 10'h000, 3'b000, 3'b111);
    // set beats wakeup
    stop_req_step(1, 1, 1, 2'b00, 10'h000, 3'b111, 3'b111);
    stop_req_step(0, 0, 0, 2'b00, 10'h000, 3'b010, 3'b101);
    // system reset forces all requests low
    @(posedge sys_clk);
    nrst_in <= 1'b0;
    {c1_deepsleep, c2_deepsleep, d3_deepsleep} <= 3'b111;
    repeat (2) @(negedge sys_clk);
    check_bit(sys_rst_n, 1'b0, "sys_rst_n");
    for (int n = 2; n <= 3; n++) begin
      @(negedge sys_clk);
      check_bit(pwr_d1_req, 1'b0, "pwr_d1_req");
      check_bit(pwr_d2_req, 1'b0, "pwr_d2_req");
      check_bit(pwr_d3_req, 1'b0, "pwr_d3_req");
    end
  endtask

  // ========================================================================
  // main sequence
  // ========================================================================
  initial begin
    seed = 32'h77240781;
    void'($urandom(seed));
    reset   = 1'b1;
    arcg_on = 1'b1;
    {nrst_in, pwr_vcore_ok, obl_done, flash_obl_reload, flash_power_ok, hsi_rdy} = '0;
    {pwr_d1_ok, pwr_d2_ok, pwr_bor_rst, lpwr1_rst, lpwr2_rst, iwdg1_rst, iwdg2_rst} = '0;
    {wwdg1_rst, wwdg2_rst, ww1rsc, ww2rsc, cpu1_sftrst, cpu2_sftrst} = '0;
    {c1_deepsleep, c2_deepsleep, d3_deepsleep, c2_per_alloc_d1, c1_per_alloc_d2} = '0;
    {axi_d1_busy, ahb3_d1_busy, apb3_d1_busy, flash_busy, ahb1_d2_busy} = '0;
    {ahb2_d2_busy, apb1_d2_busy, apb2_d2_busy, ahb4_d3_busy, apb4_d3_busy} = '0;
    {pwr_d1_wkup, pwr_d2_wkup, pwr_d3_wkup} = '0;
    @(posedge sys_clk);
    @(negedge sys_clk);
    // everything in reset
    check_dom(rst_vec(), '0, "domain resets");
    check_dom(clk_vec(), '0, "domain clock enables");
    check_bit(cpu1_clk_en || cpu2_clk_en, 1'b0, "cpu clock enables");
    check_bit(rst_pin_drive, 1'b0, "rst_pin_drive");
    check_bit(pwr_d1_req || pwr_d2_req || pwr_d3_req, 1'b0, "stop requests");
    @(posedge sys_clk);
    reset <= 1'b0;
    @(negedge sys_clk);
    $display("power-up sequence");
    power_up_sequence();
    hold_release_gating();
    arcg_bypass();
    watchdog_bus_resets();
    pin_drive_random();
    low_power_requests();
    $display("Done: no errors");
    $finish;
  end

endmodule
